// File: verilog/proc_pkg.sv
`default_nettype none

package proc_pkg;

  // datapath and address width
  localparam int xlen = 32;

  typedef logic [4:0] reg_addr_t;

  // instruction fields in the r-type layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } inst_fields_t;

  // ----------------------------------------
  // opcodes and csr numbers
  // ----------------------------------------
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [11:0] csr_mngr2proc = 12'hfc0;
  localparam logic [11:0] csr_proc2mngr = 12'h7c0;

  // casez patterns for the supported instructions
  localparam logic [31:0] inst_nop  = 32'h0000_0013;
  localparam logic [31:0] inst_add  = {7'b0000000, 10'b??????????, 3'b000, 5'b?????, opc_op};
  localparam logic [31:0] inst_sub  = {7'b0100000, 10'b??????????, 3'b000, 5'b?????, opc_op};
  localparam logic [31:0] inst_and  = {7'b0000000, 10'b??????????, 3'b111, 5'b?????, opc_op};
  localparam logic [31:0] inst_or   = {7'b0000000, 10'b??????????, 3'b110, 5'b?????, opc_op};
  localparam logic [31:0] inst_xor  = {7'b0000000, 10'b??????????, 3'b100, 5'b?????, opc_op};
  localparam logic [31:0] inst_addi = {17'b?????????????????, 3'b000, 5'b?????, opc_op_imm};
  localparam logic [31:0] inst_bne  = {17'b?????????????????, 3'b001, 5'b?????, opc_branch};
  // csrr rd, mngr2proc is csrrs with rs1 = x0
  localparam logic [31:0] inst_csrr = {csr_mngr2proc, 5'b00000, 3'b010, 5'b?????, opc_system};
  // csrw proc2mngr, rs1 is csrrw with rd = x0
  localparam logic [31:0] inst_csrw = {csr_proc2mngr, 5'b?????, 3'b001, 5'b00000, opc_system};

  // ----------------------------------------
  // control encodings
  // ----------------------------------------
  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_cp0, alu_cp1
  } alu_fn_t;

  typedef enum logic [0:0] {imm_i, imm_b} imm_type_t;

  typedef enum logic [1:0] {op2_rf, op2_imm, op2_mngr} op2_sel_t;

  typedef enum logic [0:0] {pc_plus4, pc_br} pc_sel_t;

endpackage

`default_nettype wire

// File: verilog/ctrl_dpath_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_dpath_if;
  import proc_pkg::*;

  // per-stage register enables
  logic      reg_en_f;
  logic      reg_en_d;
  logic      reg_en_x;
  logic      reg_en_m;
  logic      reg_en_w;

  // mux selects and functions
  pc_sel_t   pc_sel_f;
  op2_sel_t  op2_sel_d;
  imm_type_t imm_type_d;
  alu_fn_t   alu_fn_x;

  // register file write port
  logic      rf_wen_w;
  reg_addr_t rf_waddr_w;

  // status from the datapath
  logic [xlen-1:0] inst_d;
  logic            br_cond_eq_x;

  modport ctrl (
    output reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w,
    output pc_sel_f, op2_sel_d, imm_type_d, alu_fn_x, rf_wen_w, rf_waddr_w,
    input  inst_d, br_cond_eq_x
  );

  modport dpath (
    input  reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w,
    input  pc_sel_f, op2_sel_d, imm_type_d, alu_fn_x, rf_wen_w, rf_waddr_w,
    output inst_d, br_cond_eq_x
  );

endinterface

`default_nettype wire

// File: verilog/proc_alu.sv
`timescale 1ns/1ps
`default_nettype none

module proc_alu (
  input  logic [proc_pkg::xlen-1:0] op0,
  input  logic [proc_pkg::xlen-1:0] op1,
  input  proc_pkg::alu_fn_t         fn,
  output logic [proc_pkg::xlen-1:0] result,
  output logic                      eq
);
  import proc_pkg::*;

  always_comb begin
    case (fn)
      alu_add: result = op0 + op1;
      alu_sub: result = op0 - op1;
      alu_and: result = op0 & op1;
      alu_or:  result = op0 | op1;
      alu_xor: result = op0 ^ op1;
      // copies used by csrw and csrr
      alu_cp0: result = op0;
      alu_cp1: result = op1;
      default: result = '0;
    endcase
  end

  // branch compare for bne
  assign eq = (op0 == op1);

endmodule

`default_nettype wire

// File: verilog/proc_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module proc_regfile (
  input  logic                      clk,
  input  proc_pkg::reg_addr_t       raddr0,
  input  proc_pkg::reg_addr_t       raddr1,
  output logic [proc_pkg::xlen-1:0] rdata0,
  output logic [proc_pkg::xlen-1:0] rdata1,
  input  logic                      wen,
  input  proc_pkg::reg_addr_t       waddr,
  input  logic [proc_pkg::xlen-1:0] wdata
);
  import proc_pkg::*;

  logic [xlen-1:0] mem [32];

  // writes to x0 are ignored
  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      mem[waddr] <= wdata;
    end
  end

  // x0 reads as zero
  assign rdata0 = (raddr0 == '0) ? '0 : mem[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];

  // a write aimed at x0 leaves the stored x0 entry as it was
  assert property (@(posedge clk)
    wen && waddr == '0 |=> mem[0] === $past(mem[0]));

endmodule

`default_nettype wire

// File: verilog/proc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module proc_ctrl (
  input  logic       clk,
  input  logic       reset,
  ctrl_dpath_if.ctrl cd,
  output logic       imem_req_val,
  output logic       imem_resp_rdy,
  input  logic       imem_resp_val,
  output logic       imem_resp_drop,
  input  logic       mngr2proc_val,
  output logic       mngr2proc_rdy,
  output logic       proc2mngr_val,
  input  logic       proc2mngr_rdy,
  output logic       commit_inst
);
  import proc_pkg::*;

  localparam logic n = 1'b0;
  localparam logic y = 1'b1;

  logic val_f, val_d, val_x, val_m, val_w;
  logic ostall_f, ostall_d, ostall_w;
  logic stall_f, stall_d, stall_x, stall_m, stall_w;
  logic osquash_x;
  logic squash_f, squash_d;
  logic next_val_f, next_val_d, next_val_x, next_val_m;

  // ----------------------------------------
  // F stage
  // ----------------------------------------
  // fetch starts the cycle after reset is released
  logic run;

  always_ff @(posedge clk) begin
    if (reset) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // a squash refetches even while stalled
  assign cd.reg_en_f = run && (!stall_f || squash_f);

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (cd.reg_en_f) begin
      val_f <= 1'b1;
    end
  end

  assign ostall_f = val_f && !imem_resp_val;
  assign stall_f  = val_f && (ostall_f || ostall_d || ostall_w);
  assign squash_f = val_f && osquash_x;

  // request and response move together so one response is in flight
  assign imem_req_val   = cd.reg_en_f;
  assign imem_resp_rdy  = cd.reg_en_f;
  assign imem_resp_drop = squash_f;

  assign cd.pc_sel_f = osquash_x ? pc_br : pc_plus4;
  assign next_val_f  = val_f && !stall_f && !squash_f;

  // ----------------------------------------
  // D stage
  // ----------------------------------------
  assign cd.reg_en_d = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (cd.reg_en_d) begin
      val_d <= next_val_f;
    end
  end

  inst_fields_t fields_d;
  assign fields_d = cd.inst_d;

  logic      br_bne_d, rs1_en_d, rs2_en_d, rf_wen_d, csrr_d, csrw_d;
  alu_fn_t   alu_fn_d;
  imm_type_t imm_type_d;
  op2_sel_t  op2_sel_d;

  task automatic cs(input logic br, input imm_type_t imm, input logic rs1_en,
                    input op2_sel_t op2, input logic rs2_en, input alu_fn_t fn,
                    input logic wen, input logic csrr, input logic csrw);
    br_bne_d   = br;
    imm_type_d = imm;
    rs1_en_d   = rs1_en;
    op2_sel_d  = op2;
    rs2_en_d   = rs2_en;
    alu_fn_d   = fn;
    rf_wen_d   = wen;
    csrr_d     = csrr;
    csrw_d     = csrw;
  endtask

  // decode table
  always_comb begin
    casez (cd.inst_d)
      //            bne imm    rs1 op2       rs2 alu      wen csrr csrw
      inst_nop:  cs(n,  imm_i, n,  op2_rf,   n,  alu_add, n,  n,   n);
      inst_add:  cs(n,  imm_i, y,  op2_rf,   y,  alu_add, y,  n,   n);
      inst_addi: cs(n,  imm_i, y,  op2_imm,  n,  alu_add, y,  n,   n);
      inst_sub:  cs(n,  imm_i, y,  op2_rf,   y,  alu_sub, y,  n,   n);
      inst_and:  cs(n,  imm_i, y,  op2_rf,   y,  alu_and, y,  n,   n);
      inst_or:   cs(n,  imm_i, y,  op2_rf,   y,  alu_or,  y,  n,   n);
      inst_xor:  cs(n,  imm_i, y,  op2_rf,   y,  alu_xor, y,  n,   n);
      inst_bne:  cs(y,  imm_b, y,  op2_rf,   y,  alu_add, n,  n,   n);
      inst_csrr: cs(n,  imm_i, n,  op2_mngr, n,  alu_cp1, y,  y,   n);
      inst_csrw: cs(n,  imm_i, y,  op2_rf,   n,  alu_cp0, n,  n,   y);
      // anything else passes through as a bubble
      default:   cs(n,  imm_i, n,  op2_rf,   n,  alu_add, n,  n,   n);
    endcase
  end

  assign cd.imm_type_d = imm_type_d;
  assign cd.op2_sel_d  = op2_sel_d;

  logic      rf_wen_x, rf_wen_m, rf_wen_pend_w;
  reg_addr_t rf_waddr_x, rf_waddr_m;

  // raw hazard against one later stage with x0 excluded
  function automatic logic raw(input logic en, input reg_addr_t rs, input logic v,
                               input logic wen, input reg_addr_t wa);
    return en && v && wen && (rs == wa) && (wa != '0);
  endfunction

  logic ostall_hazard_d;
  assign ostall_hazard_d =
      raw(rs1_en_d, fields_d.rs1, val_x, rf_wen_x, rf_waddr_x) ||
      raw(rs1_en_d, fields_d.rs1, val_m, rf_wen_m, rf_waddr_m) ||
      raw(rs1_en_d, fields_d.rs1, val_w, rf_wen_pend_w, cd.rf_waddr_w) ||
      raw(rs2_en_d, fields_d.rs2, val_x, rf_wen_x, rf_waddr_x) ||
      raw(rs2_en_d, fields_d.rs2, val_m, rf_wen_m, rf_waddr_m) ||
      raw(rs2_en_d, fields_d.rs2, val_w, rf_wen_pend_w, cd.rf_waddr_w);

  assign ostall_d = val_d && ((csrr_d && !mngr2proc_val) || ostall_hazard_d);
  assign stall_d  = val_d && (ostall_d || ostall_w);
  assign squash_d = val_d && osquash_x;

  // a squashed csrr must not consume the manager value
  assign mngr2proc_rdy = val_d && !stall_d && !squash_d && csrr_d;
  assign next_val_d    = val_d && !stall_d && !squash_d;

  // ----------------------------------------
  // X stage
  // ----------------------------------------
  assign cd.reg_en_x = !stall_x;

  logic br_bne_x, p2m_x;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
    end else if (cd.reg_en_x) begin
      val_x       <= next_val_d;
      rf_wen_x    <= rf_wen_d;
      rf_waddr_x  <= fields_d.rd;
      br_bne_x    <= br_bne_d;
      p2m_x       <= csrw_d;
      cd.alu_fn_x <= alu_fn_d;
    end
  end

  assign stall_x    = val_x && ostall_w;
  // taken bne squashes F and D once it is free to leave X
  assign osquash_x  = val_x && br_bne_x && !cd.br_cond_eq_x && !stall_x;
  assign next_val_x = val_x && !stall_x;

  // ----------------------------------------
  // M stage
  // ----------------------------------------
  assign cd.reg_en_m = !stall_m;

  logic p2m_m;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_m <= 1'b0;
    end else if (cd.reg_en_m) begin
      val_m      <= next_val_x;
      rf_wen_m   <= rf_wen_x;
      rf_waddr_m <= rf_waddr_x;
      p2m_m      <= p2m_x;
    end
  end

  assign stall_m    = val_m && ostall_w;
  assign next_val_m = val_m && !stall_m;

  // ----------------------------------------
  // W stage
  // ----------------------------------------
  assign cd.reg_en_w = !stall_w;

  logic p2m_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (cd.reg_en_w) begin
      val_w         <= next_val_m;
      rf_wen_pend_w <= rf_wen_m;
      cd.rf_waddr_w <= rf_waddr_m;
      p2m_w         <= p2m_m;
    end
  end

  assign cd.rf_wen_w = val_w && rf_wen_pend_w;

  // csrw waits in W for the sink
  assign ostall_w      = val_w && p2m_w && !proc2mngr_rdy;
  assign stall_w       = val_w && ostall_w;
  assign proc2mngr_val = val_w && p2m_w;
  assign commit_inst   = val_w && !stall_w;

  // output stays offered until the sink takes it
  assert property (@(posedge clk) disable iff (reset)
    proc2mngr_val && !proc2mngr_rdy |=> proc2mngr_val);

  // the squashing bne moves on to M and leaves only bubbles behind it
  assert property (@(posedge clk) disable iff (reset)
    osquash_x |=> val_m && !val_x && !val_d);

endmodule

`default_nettype wire

// File: verilog/proc_dpath.sv
`timescale 1ns/1ps
`default_nettype none

module proc_dpath #(
  parameter logic [proc_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                      clk,
  input  logic                      reset,
  ctrl_dpath_if.dpath               cd,
  output logic [proc_pkg::xlen-1:0] imem_req_addr,
  input  logic [proc_pkg::xlen-1:0] imem_resp_data,
  input  logic [proc_pkg::xlen-1:0] mngr2proc_data,
  output logic [proc_pkg::xlen-1:0] proc2mngr_data
);
  import proc_pkg::*;

  // ----------------------------------------
  // F stage
  // ----------------------------------------
  logic [xlen-1:0] pc_f, pc_next_f, br_target_x;

  // the request address is the next pc, not the held one
  assign pc_next_f     = (cd.pc_sel_f == pc_br) ? br_target_x : pc_f + xlen'(4);
  assign imem_req_addr = pc_next_f;

  // starts one word early so the first fetch hits reset_pc
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= reset_pc - xlen'(4);
    end else if (cd.reg_en_f) begin
      pc_f <= pc_next_f;
    end
  end

  // ----------------------------------------
  // D stage
  // ----------------------------------------
  logic [xlen-1:0] pc_d;

  always_ff @(posedge clk) begin
    if (cd.reg_en_d) begin
      cd.inst_d <= imem_resp_data;
      pc_d      <= pc_f;
    end
  end

  inst_fields_t    fields_d;
  logic [xlen-1:0] rdata0_d, rdata1_d, imm_i_d, imm_b_d, imm_d, op1_d;
  logic [xlen-1:0] result_w;

  assign fields_d = cd.inst_d;

  proc_regfile rf (
    .clk    (clk),
    .raddr0 (fields_d.rs1),
    .raddr1 (fields_d.rs2),
    .rdata0 (rdata0_d),
    .rdata1 (rdata1_d),
    .wen    (cd.rf_wen_w),
    .waddr  (cd.rf_waddr_w),
    .wdata  (result_w)
  );

  // sign extended immediates
  assign imm_i_d = {{20{cd.inst_d[31]}}, cd.inst_d[31:20]};
  assign imm_b_d = {{20{cd.inst_d[31]}}, cd.inst_d[7], cd.inst_d[30:25],
                    cd.inst_d[11:8], 1'b0};
  assign imm_d   = (cd.imm_type_d == imm_b) ? imm_b_d : imm_i_d;

  always_comb begin
    case (cd.op2_sel_d)
      op2_imm:  op1_d = imm_d;
      op2_mngr: op1_d = mngr2proc_data;
      default:  op1_d = rdata1_d;
    endcase
  end

  // ----------------------------------------
  // X stage
  // ----------------------------------------
  logic [xlen-1:0] op0_x, op1_x, imm_x, pc_x, result_x;

  always_ff @(posedge clk) begin
    if (cd.reg_en_x) begin
      op0_x <= rdata0_d;
      op1_x <= op1_d;
      imm_x <= imm_d;
      pc_x  <= pc_d;
    end
  end

  assign br_target_x = pc_x + imm_x;

  proc_alu alu (
    .op0    (op0_x),
    .op1    (op1_x),
    .fn     (cd.alu_fn_x),
    .result (result_x),
    .eq     (cd.br_cond_eq_x)
  );

  // ----------------------------------------
  // M and W stages
  // ----------------------------------------
  logic [xlen-1:0] result_m;

  always_ff @(posedge clk) begin
    if (cd.reg_en_m) begin
      result_m <= result_x;
    end
  end

  always_ff @(posedge clk) begin
    if (cd.reg_en_w) begin
      result_w <= result_m;
    end
  end

  // csrw value rides the same path as a writeback
  assign proc2mngr_data = result_w;

endmodule

`default_nettype wire

// File: verilog/proc_top.sv
`timescale 1ns/1ps
`default_nettype none

module proc_top #(
  parameter logic [proc_pkg::xlen-1:0] reset_pc = 32'h0000_0200
) (
  input  logic                      clk,
  input  logic                      reset,
  output logic                      imem_req_val,
  output logic [proc_pkg::xlen-1:0] imem_req_addr,
  input  logic                      imem_resp_val,
  output logic                      imem_resp_rdy,
  input  logic [proc_pkg::xlen-1:0] imem_resp_data,
  output logic                      imem_resp_drop,
  input  logic                      mngr2proc_val,
  output logic                      mngr2proc_rdy,
  input  logic [proc_pkg::xlen-1:0] mngr2proc_data,
  output logic                      proc2mngr_val,
  input  logic                      proc2mngr_rdy,
  output logic [proc_pkg::xlen-1:0] proc2mngr_data,
  output logic                      commit_inst
);

  // control to datapath bundle
  ctrl_dpath_if cd ();

  proc_ctrl ctrl (
    .clk            (clk),
    .reset          (reset),
    .cd             (cd.ctrl),
    .imem_req_val   (imem_req_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_drop (imem_resp_drop),
    .mngr2proc_val  (mngr2proc_val),
    .mngr2proc_rdy  (mngr2proc_rdy),
    .proc2mngr_val  (proc2mngr_val),
    .proc2mngr_rdy  (proc2mngr_rdy),
    .commit_inst    (commit_inst)
  );

  proc_dpath #(
    .reset_pc (reset_pc)
  ) dpath (
    .clk            (clk),
    .reset          (reset),
    .cd             (cd.dpath),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_data (imem_resp_data),
    .mngr2proc_data (mngr2proc_data),
    .proc2mngr_data (proc2mngr_data)
  );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns = 8
) (
  output logic clk
);

  // free running clock starts low so the first rising edge is at half a period
  initial begin
    clk = 1'b0;
  end

  always #(period_ns / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: test/proc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module proc_checker #(
  parameter logic [31:0] reset_pc = '0
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        imem_req_val,
  input  logic [31:0] imem_req_addr,
  input  logic        imem_resp_rdy,
  input  logic        imem_resp_drop,
  input  logic        mngr2proc_rdy,
  input  logic        proc2mngr_val,
  input  logic        proc2mngr_rdy,
  input  logic [31:0] proc2mngr_data,
  input  logic        commit_inst,
  output logic        done,
  output int          errors
);

  // expected output stream filled before reset is released
  logic [31:0] exp_val [64];
  string       exp_name [64];
  int          exp_n = 0;
  int          out_idx = 0;
  int          commit_count = 0;
  int          commit_target = 0;
  int          drop_count = 0;
  int          drop_target = 0;
  int          mismatches = 0;
  int          others = 0;
  logic        first_req_seen = 1'b0;
  logic        reset_seen = 1'b0;

  initial begin
    done = 1'b0;
  end

  assign errors = mismatches + others;

  task add_expected(input logic [31:0] value, input string name);
    exp_val[exp_n]  = value;
    exp_name[exp_n] = name;
    exp_n++;
  endtask

  task set_commit_target(input int n);
    commit_target = n;
  endtask

  // one dropped response per taken bne
  task set_drop_target(input int n);
    drop_target = n;
  endtask

  // ----------------------------------------
  // output stream compare
  // ----------------------------------------
  task check_output(input logic [31:0] data);
    if (out_idx >= exp_n) begin
      $display("extra output %h arrived after all %0d expected values", data, exp_n);
      others++;
    end else begin
      if (data !== exp_val[out_idx]) begin
        $display("Mismatch %s: expected %h actual %h", exp_name[out_idx],
                 exp_val[out_idx], data);
        mismatches++;
      end
      out_idx++;
      // the last output belongs to the last instruction so the totals are final here
      if (out_idx == exp_n) begin
        if (commit_count != commit_target) begin
          $display("Mismatch commit_count: expected %0d actual %0d", commit_target,
                   commit_count);
          mismatches++;
        end
        if (drop_count != drop_target) begin
          $display("Mismatch drop_count: expected %0d actual %0d", drop_target,
                   drop_count);
          mismatches++;
        end
        done = 1'b1;
      end
    end
  endtask

  // sampled on the rising edge while inputs settle 1 ns after it
  always @(posedge clk) begin
    if (reset) begin
      // first edge only loads the reset values
      if (reset_seen && (imem_req_val !== 1'b0 || mngr2proc_rdy !== 1'b0 ||
                         proc2mngr_val !== 1'b0 || commit_inst !== 1'b0)) begin
        $display("a request, ready, valid or commit output is not low during reset");
        others++;
      end
      reset_seen = 1'b1;
    end else begin
      if (imem_req_val === 1'b1 && !first_req_seen) begin
        first_req_seen = 1'b1;
        if (imem_req_addr !== reset_pc) begin
          $display("Mismatch first_fetch: expected %h actual %h", reset_pc, imem_req_addr);
          mismatches++;
        end
      end
      if (imem_resp_rdy !== imem_req_val) begin
        $display("instruction response ready does not follow the request valid");
        others++;
      end
      if (imem_resp_drop === 1'b1) begin
        if (imem_resp_rdy !== 1'b1) begin
          $display("a response was dropped in a cycle where it was not accepted");
          others++;
        end
        drop_count++;
      end
      if (commit_inst === 1'b1) begin
        commit_count++;
      end
      if (proc2mngr_val === 1'b1 && proc2mngr_rdy === 1'b1) begin
        check_output(proc2mngr_data);
      end
    end
  end

  task print_summary(input logic timed_out);
    $display("checker: %0d mismatches, %0d other errors, %0d timeouts, %0d/%0d outputs",
             mismatches, others, timed_out ? 1 : 0, out_idx, exp_n);
  endtask

endmodule

`default_nettype wire

// File: test/proc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module proc_tb;

  localparam logic [31:0] tb_reset_pc = 32'h0000_0100;

  logic        clk, reset;
  logic        imem_req_val, imem_resp_val, imem_resp_rdy, imem_resp_drop;
  logic [31:0] imem_req_addr, imem_resp_data;
  logic        mngr2proc_val, mngr2proc_rdy, proc2mngr_val, proc2mngr_rdy;
  logic [31:0] mngr2proc_data, proc2mngr_data;
  logic        commit_inst;
  logic        chk_done;
  int          chk_errors;

  tb_clock #(.period_ns(8)) clkgen (.clk(clk));

  proc_top #(
    .reset_pc (tb_reset_pc)
  ) DUT (
    .clk            (clk),
    .reset          (reset),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_data (imem_resp_data),
    .imem_resp_drop (imem_resp_drop),
    .mngr2proc_val  (mngr2proc_val),
    .mngr2proc_rdy  (mngr2proc_rdy),
    .mngr2proc_data (mngr2proc_data),
    .proc2mngr_val  (proc2mngr_val),
    .proc2mngr_rdy  (proc2mngr_rdy),
    .proc2mngr_data (proc2mngr_data),
    .commit_inst    (commit_inst)
  );

  proc_checker #(
    .reset_pc (tb_reset_pc)
  ) chk (
    .clk            (clk),
    .reset          (reset),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_drop (imem_resp_drop),
    .mngr2proc_rdy  (mngr2proc_rdy),
    .proc2mngr_val  (proc2mngr_val),
    .proc2mngr_rdy  (proc2mngr_rdy),
    .proc2mngr_data (proc2mngr_data),
    .commit_inst    (commit_inst),
    .done           (chk_done),
    .errors         (chk_errors)
  );

  // program image, manager inputs and expected outputs
  logic [31:0] prog [64];
  string       prog_name [64];
  int          prog_len = 0;
  logic [31:0] mngr_in [16];
  int          mngr_n = 0;
  logic [31:0] exp_out [64];
  string       exp_tag [64];
  int          exp_n = 0;
  int          taken_n = 0;

  int          commit_target, limit;
  int          cycles = 0;
  logic        timed_out;

  // ----------------------------------------
  // instruction encoders
  // ----------------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  // byte offset relative to the bne itself
  function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input int off);
    logic [12:0] b;
    b = 13'(off);
    return {b[12], b[10:5], rs2, rs1, 3'b001, b[4:1], b[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_csrr(input logic [4:0] rd);
    return {12'hfc0, 5'd0, 3'b010, rd, 7'b1110011};
  endfunction

  function automatic logic [31:0] enc_csrw(input logic [4:0] rs1);
    return {12'h7c0, rs1, 3'b001, 5'd0, 7'b1110011};
  endfunction

  // addi x0 past the program with an immediate folded from the whole address
  function automatic logic [31:0] filler_word(input logic [31:0] a);
    logic [11:0] f;
    f = a[11:0] ^ a[23:12] ^ {4'h0, a[31:24]};
    return enc_addi(5'd0, 5'd0, f);
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] a);
    logic [31:0] idx;
    idx = (a - tb_reset_pc) >> 2;
    if (a >= tb_reset_pc && a[1:0] == 2'b00 && idx < prog_len) begin
      return prog[idx];
    end
    return filler_word(a);
  endfunction

  task place(input logic [31:0] w, input string name);
    prog[prog_len]      = w;
    prog_name[prog_len] = name;
    prog_len++;
  endtask

  // ----------------------------------------
  // test program
  // ----------------------------------------
  task build_program();
    // arithmetic chain where every result feeds the next instruction
    place(enc_csrr(5'd1), "");
    place(enc_csrr(5'd2), "");
    place(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), "");
    place(enc_csrw(5'd3), "add");
    place(enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), "");
    place(enc_csrw(5'd4), "sub");
    place(enc_r(7'h00, 3'b111, 5'd5, 5'd4, 5'd2), "");
    place(enc_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd1), "");
    place(enc_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd3), "");
    place(enc_csrw(5'd5), "and");
    place(enc_csrw(5'd6), "or");
    place(enc_csrw(5'd7), "xor");
    place(enc_addi(5'd8, 5'd7, -12'sd13), "");
    place(enc_csrw(5'd8), "addi");
    place(enc_addi(5'd0, 5'd0, 12'd0), "");
    // x0 written twice and then read
    place(enc_csrr(5'd0), "");
    place(enc_addi(5'd0, 5'd1, 12'd77), "");
    place(enc_csrw(5'd0), "x0");
    // countdown loop with a running sum
    place(enc_addi(5'd10, 5'd0, 12'd3), "");
    place(enc_addi(5'd11, 5'd0, 12'd0), "");
    place(enc_addi(5'd13, 5'd0, 12'h5a5), "");
    place(enc_csrr(5'd12), "");
    place(enc_r(7'h00, 3'b000, 5'd11, 5'd11, 5'd12), "");
    place(enc_csrw(5'd11), "loop");
    place(enc_addi(5'd10, 5'd10, -12'sd1), "");
    place(enc_bne(5'd10, 5'd0, -16), "");
    // sits on the wrong path of every taken bne
    place(enc_csrw(5'd13), "marker");
    place(enc_r(7'h00, 3'b100, 5'd14, 5'd11, 5'd13), "");
    place(enc_csrw(5'd14), "final");
  endtask

  // ----------------------------------------
  // reference model stepping one instruction at a time
  // ----------------------------------------
  function automatic int execute_program();
    logic [31:0] regs [32];
    logic [31:0] pc, next_pc, w, imm_i, imm_b, idx;
    logic [4:0]  rd, rs1, rs2;
    int          in_idx, commits;
    logic        running;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    pc      = tb_reset_pc;
    in_idx  = 0;
    commits = 0;
    running = 1'b1;
    exp_n   = 0;
    taken_n = 0;
    while (running && commits < 1000) begin
      idx = (pc - tb_reset_pc) >> 2;
      if (pc < tb_reset_pc || idx >= prog_len) begin
        running = 1'b0;
      end else begin
        w       = prog[idx];
        rd      = w[11:7];
        rs1     = w[19:15];
        rs2     = w[24:20];
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        next_pc = pc + 32'd4;
        case (w[6:0])
          7'b0110011: begin
            // funct7 and funct3 together pick the operation
            case ({w[31:25], w[14:12]})
              10'b0000000_000: regs[rd] = regs[rs1] + regs[rs2];
              10'b0100000_000: regs[rd] = regs[rs1] - regs[rs2];
              10'b0000000_111: regs[rd] = regs[rs1] & regs[rs2];
              10'b0000000_110: regs[rd] = regs[rs1] | regs[rs2];
              10'b0000000_100: regs[rd] = regs[rs1] ^ regs[rs2];
              default: ;
            endcase
          end
          7'b0010011: regs[rd] = regs[rs1] + imm_i;
          7'b1100011: begin
            if (regs[rs1] != regs[rs2]) begin
              next_pc = pc + imm_b;
              taken_n++;
            end
          end
          7'b1110011: begin
            if (w[14:12] == 3'b010) begin
              regs[rd] = mngr_in[in_idx];
              in_idx++;
            end else begin
              exp_out[exp_n] = regs[rs1];
              exp_tag[exp_n] = prog_name[idx];
              exp_n++;
            end
          end
          default: ;
        endcase
        regs[0] = '0;
        pc      = next_pc;
        commits++;
      end
    end
    return commits;
  endfunction

  // ----------------------------------------
  // instruction memory answers one cycle after the request
  // ----------------------------------------
  logic        mem_reset, mem_fire;
  logic [31:0] mem_addr;

  always @(posedge clk) begin
    mem_reset = reset;
    mem_fire  = (imem_req_val === 1'b1);
    mem_addr  = imem_req_addr;
    #1;
    if (mem_reset) begin
      imem_resp_val = 1'b0;
    end else if (mem_fire) begin
      // a new request also consumes the held response
      imem_resp_val  = 1'b1;
      imem_resp_data = fetch_word(mem_addr);
    end
  end

  // manager source holds each value until it is taken
  logic src_reset, src_fire;
  int   src_idx = 0;

  always @(posedge clk) begin
    src_reset = reset;
    src_fire  = (mngr2proc_val === 1'b1 && mngr2proc_rdy === 1'b1);
    #1;
    if (src_reset) begin
      mngr2proc_val = 1'b0;
    end else begin
      if (src_fire) begin
        src_idx++;
      end
      if (src_fire || !mngr2proc_val) begin
        mngr2proc_val  = (src_idx < mngr_n) && ($urandom % 3 != 0);
        mngr2proc_data = mngr_in[src_idx];
      end
    end
  end

  // output sink with random back-pressure
  logic snk_reset;

  always @(posedge clk) begin
    snk_reset = reset;
    #1;
    proc2mngr_rdy = !snk_reset && ($urandom % 4 != 0);
  end

  always @(posedge clk) begin
    cycles++;
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(46524));
    reset          = 1'b1;
    imem_resp_val  = 1'b0;
    imem_resp_data = '0;
    mngr2proc_val  = 1'b0;
    mngr2proc_data = '0;
    proc2mngr_rdy  = 1'b0;
    for (int i = 0; i < 6; i++) begin
      mngr_in[i] = $urandom;
    end
    mngr_n = 6;
    build_program();
    commit_target = execute_program();
    for (int i = 0; i < exp_n; i++) begin
      chk.add_expected(exp_out[i], exp_tag[i]);
    end
    chk.set_commit_target(commit_target);
    chk.set_drop_target(taken_n);
    limit = commit_target * 20 + 200;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    while (chk_done !== 1'b1 && cycles < limit) begin
      @(posedge clk);
    end
    timed_out = (chk_done !== 1'b1);
    if (timed_out) begin
      $display("timeout: the last expected output did not arrive within %0d cycles", limit);
    end
    chk.print_summary(timed_out);
    if (timed_out || chk_errors != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/proc_pkg.sv
verilog/ctrl_dpath_if.sv
verilog/proc_alu.sv
verilog/proc_regfile.sv
verilog/proc_ctrl.sv
verilog/proc_dpath.sv
verilog/proc_top.sv
test/tb_clock.sv
test/proc_checker.sv
test/proc_tb.sv
